// File: lcu_ctrl.f
lcu_sched_pkg.sv
mode_buf_pkg.sv
lcu_frame_cfg.sv
lcu_stage_sched.sv
mode_ram_1p.sv
mode_pingpong.sv
lcu_ctrl_top.sv
lcu_ctrl_checker.sv
tb_clkgen.sv
lcu_ctrl_tb.sv

// File: Bender.yml
package:
  name: lcu_ctrl

sources:
  - lcu_sched_pkg.sv
  - mode_buf_pkg.sv
  - lcu_frame_cfg.sv
  - lcu_stage_sched.sv
  - mode_ram_1p.sv
  - mode_pingpong.sv
  - lcu_ctrl_top.sv
  - target: test
    files:
      - lcu_ctrl_checker.sv
      - tb_clkgen.sv
      - lcu_ctrl_tb.sv

// File: lcu_ctrl_tb.sv
/*
  Testbench for lcu_ctrl_top. Engine models answer each start with one done
  after 1 to 8 cycles. Start counts are compared when sys_done_o rises.
  The mode buffer check relies on an odd number of enc starts in the P frame.
*/
`timescale 1ns/1ps
`default_nettype none

module lcu_ctrl_tb;
  import lcu_sched_pkg::*;
  import mode_buf_pkg::*;

  localparam int WAIT_LIMIT = 2000;  // cycles per wait loop

  typedef struct packed {
    int fetch;
    int pre_i;
    int enc;
  } start_counts_t;

  logic               clk;
  logic               rst_n;
  logic               sys_start;
  frame_cfg_t         sys_cfg;
  frame_cfg_t         exp_cfg;  // config of the running frame
  logic               sys_done;
  engine_strobe_t     eng_start;
  engine_strobe_t     eng_done;
  logic [2:0]         start_vec;
  logic [2:0]         done_vec;  // fetch, pre_i, enc
  mode_wr_t           md_wr;
  logic [MODE_AW-1:0] md_raddr;
  logic [MODE_DW-1:0] md_rdata;
  start_counts_t      cnt = '0;
  logic               frame_active = 1'b0;
  int                 seed = 32'h0fa3c2d8;
  int                 errors = 0;
  int                 timeouts = 0;

  tb_clkgen #(.PERIOD_NS(8.0), .RST_CYCLES(5)) u_clkgen (.clk_o(clk), .rst_n_o(rst_n));

  lcu_ctrl_top UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .sys_start_i (sys_start),
    .sys_cfg_i   (sys_cfg),
    .sys_done_o  (sys_done),
    .eng_start_o (eng_start),
    .eng_done_i  (eng_done),
    .md_wr_i     (md_wr),
    .md_raddr_i  (md_raddr),
    .md_rdata_o  (md_rdata)
  );

  bind lcu_stage_sched lcu_ctrl_checker u_checker (
    .clk     (clk),
    .rst_n   (rst_n),
    .start_i (eng_start_o),
    .slice_i (slice_i),
    .done_i  (sys_done_o)
  );

  assign start_vec = eng_start;
  assign eng_done  = engine_strobe_t'(done_vec);

  // start counts of one frame
  function automatic start_counts_t expected_starts(input frame_cfg_t cfg);
    start_counts_t c;
    int            n;
    n = (int'(cfg.x_total) + 1) * (int'(cfg.y_total) + 1);
    if (cfg.slice == SLICE_I) begin
      c = '{fetch: n + 6, pre_i: n + 1, enc: n + 1};
    end else begin
      c = '{fetch: n + 8, pre_i: 0, enc: n + 3};
    end
    return c;
  endfunction

  // mode fill pattern that depends on every address bit
  function automatic logic [MODE_DW-1:0] mode_pattern(input int addr, input int salt);
    logic [MODE_AW-1:0] a;
    a = MODE_AW'(addr);
    return MODE_DW'(a ^ (a >> 3) ^ MODE_AW'(salt * 'h2b));
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // --------------------
  // engine models
  // --------------------
  task automatic run_engine(input int idx);
    int dly;
    forever begin
      @(posedge clk);
      if (start_vec[idx]) begin
        dly = 1 + int'({$random(seed)} % 8);
        repeat (dly - 1) @(posedge clk);
        #1 done_vec[idx] = 1'b1;
        @(posedge clk);
        #1 done_vec[idx] = 1'b0;
      end
    end
  endtask

  initial run_engine(2);
  initial run_engine(1);
  initial run_engine(0);

  // counts start pulses and compares them when the frame ends
  always @(posedge clk) begin : monitor
    start_counts_t exp_cnt;
    if (frame_active && sys_done) begin
      exp_cnt = expected_starts(exp_cfg);
      check_eq("eng_start_o.fetch count", cnt.fetch, exp_cnt.fetch);
      check_eq("eng_start_o.pre_i count", cnt.pre_i, exp_cnt.pre_i);
      check_eq("eng_start_o.enc count", cnt.enc, exp_cnt.enc);
      cnt          = '0;
      frame_active = 1'b0;
    end
    if (rst_n && sys_start) frame_active = 1'b1;
    cnt.fetch += int'(start_vec[2]);
    cnt.pre_i += int'(start_vec[1]);
    cnt.enc   += int'(start_vec[0]);
  end

  // --------------------
  // stimulus
  // --------------------
  task automatic run_frame(input frame_cfg_t cfg);
    int t;
    @(posedge clk);
    #1;
    exp_cfg   = cfg;
    sys_cfg   = cfg;
    sys_start = 1'b1;
    @(posedge clk);
    #1;
    sys_start = 1'b0;
    // mid-frame change that must not reach the schedule
    sys_cfg = '{x_total: 8'hff, y_total: 8'h0f,
                slice: (cfg.slice == SLICE_I) ? SLICE_P : SLICE_I};
    check_eq("sys_done_o after start", sys_done, 0);
    t = 0;
    while (!sys_done && t < WAIT_LIMIT) begin
      @(posedge clk);
      t++;
    end
    if (!sys_done) begin
      timeouts++;
      $display("Timeout: frame did not finish, sys_done_o stayed low");
    end
  endtask

  task automatic mode_write_all(input int salt);
    for (int a = 0; a < MODE_DEPTH; a++) begin
      @(posedge clk);
      #1 md_wr = '{we: 1'b1, addr: MODE_AW'(a), data: mode_pattern(a, salt)};
    end
    @(posedge clk);
    #1 md_wr = '0;
  endtask

  // reads back old data while new data goes to the same addresses
  task automatic mode_read_check(input int salt_old, input int salt_new);
    for (int a = 0; a <= MODE_DEPTH; a++) begin
      @(posedge clk);
      #1;
      if (a > 0) begin
        check_eq($sformatf("md_rdata_o at 0x%0h", a - 1), md_rdata,
                 mode_pattern(a - 1, salt_old));
      end
      if (a < MODE_DEPTH) begin
        md_wr    = '{we: 1'b1, addr: MODE_AW'(a), data: mode_pattern(a, salt_new)};
        md_raddr = MODE_AW'(a);
      end else begin
        md_wr = '0;
      end
    end
  endtask

  initial begin : main
    int t;
    sys_start = 1'b0;
    sys_cfg   = '0;
    exp_cfg   = '0;
    done_vec  = '0;
    md_wr     = '0;
    md_raddr  = '0;

    t = 0;
    while (rst_n !== 1'b1 && t < WAIT_LIMIT) begin
      @(posedge clk);
      t++;
    end
    if (rst_n !== 1'b1) begin
      timeouts++;
      $display("Timeout: reset was never released");
    end
    #1;
    check_eq("sys_done_o after reset", sys_done, 1);
    check_eq("eng_start_o after reset", eng_start, 0);

    run_frame('{x_total: 8'd2, y_total: 8'd1, slice: SLICE_I});  // 3 x 2 lcus
    mode_write_all(1);
    // seven enc starts make the bank just filled the read bank
    run_frame('{x_total: 8'd3, y_total: 8'd0, slice: SLICE_P});  // 4 x 1 lcus
    mode_read_check(1, 2);
    repeat (4) @(posedge clk);

    $display("errors: %0d, timeouts: %0d, assertion failures: %0d",
             errors, timeouts, UUT.u_sched.u_checker.fail_count);
    if (errors == 0 && timeouts == 0 && UUT.u_sched.u_checker.fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_clkgen.sv
/*
  Testbench clock and reset source.
  Reset is held low for RST_CYCLES rising edges and released 1 ns after an edge.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter real PERIOD_NS  = 8.0,
  parameter int  RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;  // off the clock edge
  end

endmodule

`default_nettype wire

// File: lcu_ctrl_checker.sv
/*
  Strobe assertions for the phase scheduler, bound into lcu_stage_sched.
  slice_i is the latched slice type while a frame runs.
*/
`timescale 1ns/1ps
`default_nettype none

module lcu_ctrl_checker (
  input  logic                          clk,
  input  logic                          rst_n,
  input  lcu_sched_pkg::engine_strobe_t start_i,
  input  lcu_sched_pkg::slice_e         slice_i,
  input  logic                          done_i
);
  import lcu_sched_pkg::*;

  int fail_count = 0;

  // --------------------
  // single-cycle starts
  // --------------------
  a_fetch_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    start_i.fetch |=> !start_i.fetch)
    else begin
      fail_count++;
      $error("fetch start held high for two cycles");
    end

  a_pre_i_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    start_i.pre_i |=> !start_i.pre_i)
    else begin
      fail_count++;
      $error("pre_i start held high for two cycles");
    end

  a_enc_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    start_i.enc |=> !start_i.enc)
    else begin
      fail_count++;
      $error("enc start held high for two cycles");
    end

  // idle means quiet engines
  a_quiet_done: assert property (@(posedge clk) disable iff (!rst_n)
    done_i |-> (start_i == '0))
    else begin
      fail_count++;
      $error("engine start issued while sys_done_o is high");
    end

  a_no_pre_i_p: assert property (@(posedge clk) disable iff (!rst_n)
    start_i.pre_i |-> (slice_i == SLICE_I))
    else begin
      fail_count++;
      $error("pre_i started during a P frame");
    end

endmodule

`default_nettype wire

// File: lcu_ctrl_top.sv
/*
  LCU stage controller top: frame config, phase scheduler and mode ping-pong.
  All strobes are single-cycle pulses without back-pressure.
  The mode buffer swaps on each enc start pulse.
*/
`timescale 1ns/1ps
`default_nettype none

module lcu_ctrl_top (
  input  logic                             clk,
  input  logic                             rst_n,
  // system
  input  logic                             sys_start_i,
  input  lcu_sched_pkg::frame_cfg_t        sys_cfg_i,
  output logic                             sys_done_o,
  // engines
  output lcu_sched_pkg::engine_strobe_t    eng_start_o,
  input  lcu_sched_pkg::engine_strobe_t    eng_done_i,
  // intra modes
  input  mode_buf_pkg::mode_wr_t           md_wr_i,
  input  logic [mode_buf_pkg::MODE_AW-1:0] md_raddr_i,
  output logic [mode_buf_pkg::MODE_DW-1:0] md_rdata_o
);
  import lcu_sched_pkg::*;

  logic                     cfg_load;
  slice_e                   slice;
  logic [LCU_CNT_WIDTH-1:0] intra_last;
  logic [LCU_CNT_WIDTH-1:0] inter_last;

  lcu_frame_cfg u_frame_cfg (
    .clk          (clk),
    .rst_n        (rst_n),
    .load_i       (cfg_load),
    .cfg_i        (sys_cfg_i),
    .slice_o      (slice),
    .intra_last_o (intra_last),
    .inter_last_o (inter_last)
  );

  lcu_stage_sched u_sched (
    .clk          (clk),
    .rst_n        (rst_n),
    .sys_start_i  (sys_start_i),
    .slice_i      (slice),
    .intra_last_i (intra_last),
    .inter_last_i (inter_last),
    .eng_done_i   (eng_done_i),
    .eng_start_o  (eng_start_o),
    .cfg_load_o   (cfg_load),
    .sys_done_o   (sys_done_o)
  );

  // enc start hands the freshly written bank over to enc
  mode_pingpong u_mode_buf (
    .clk     (clk),
    .rst_n   (rst_n),
    .swap_i  (eng_start_o.enc),
    .wr_i    (md_wr_i),
    .raddr_i (md_raddr_i),
    .rdata_o (md_rdata_o)
  );

endmodule

`default_nettype wire

// File: mode_pingpong.sv
/*
  Two-bank intra mode buffer between pre_i and enc.
  The bank select flips on every enc start. pre_i writes the bank that enc
  is not reading. Read data is picked by the select of the address cycle,
  so a swap between address and data does not switch banks.
*/
`timescale 1ns/1ps
`default_nettype none

module mode_pingpong (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             swap_i,
  input  mode_buf_pkg::mode_wr_t           wr_i,
  input  logic [mode_buf_pkg::MODE_AW-1:0] raddr_i,
  output logic [mode_buf_pkg::MODE_DW-1:0] rdata_o
);
  import mode_buf_pkg::*;

  logic               rd_sel_q;  // bank enc reads from
  logic               rd_sel_d;  // same, aligned with read data
  mode_wr_t           bank_wr    [2];
  logic [MODE_AW-1:0] bank_raddr [2];
  logic [MODE_DW-1:0] bank_rdata [2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_sel_q <= 1'b0;
      rd_sel_d <= 1'b0;
    end else begin
      rd_sel_d <= rd_sel_q;
      if (swap_i) begin
        rd_sel_q <= ~rd_sel_q;
      end
    end
  end

  // --------------------
  // bank steering
  // --------------------
  for (genvar b = 0; b < 2; b++) begin : g_bank
    always_comb begin
      bank_wr[b]    = wr_i;
      bank_wr[b].we = wr_i.we && (rd_sel_q != 1'(b));  // write side only
      bank_raddr[b] = (rd_sel_q == 1'(b)) ? raddr_i : '0;
    end

    mode_ram_1p u_ram (
      .clk     (clk),
      .wr_i    (bank_wr[b]),
      .raddr_i (bank_raddr[b]),
      .rdata_o (bank_rdata[b])
    );
  end

  assign rdata_o = bank_rdata[rd_sel_d];

endmodule

`default_nettype wire

// File: mode_ram_1p.sv
/*
  Single-port intra mode memory, MODE_DEPTH entries.
  A write takes the port for its cycle; otherwise raddr_i is read.
  Read data appears one cycle after the address and holds until the next read.
*/
`timescale 1ns/1ps
`default_nettype none

module mode_ram_1p (
  input  logic                               clk,
  input  mode_buf_pkg::mode_wr_t             wr_i,
  input  logic [mode_buf_pkg::MODE_AW-1:0]   raddr_i,
  output logic [mode_buf_pkg::MODE_DW-1:0]   rdata_o
);
  import mode_buf_pkg::*;

  logic [MODE_DW-1:0] mem [MODE_DEPTH];
  logic [MODE_DW-1:0] rdata_q;

  always_ff @(posedge clk) begin
    if (wr_i.we) begin
      mem[wr_i.addr] <= wr_i.data;
    end else begin
      rdata_q <= mem[raddr_i];  // port free, read
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: lcu_stage_sched.sv
/*
  Phase scheduler for fetch, pre_i and enc over one frame.
  Engines answer each start with exactly one done pulse, never before the start.
  A done on an already set flag is absorbed. sys_start_i is only taken in IDLE.
  Start pulses and sys_done_o are registered.
*/
`timescale 1ns/1ps
`default_nettype none

module lcu_stage_sched (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    sys_start_i,
  input  lcu_sched_pkg::slice_e                   slice_i,
  input  logic [lcu_sched_pkg::LCU_CNT_WIDTH-1:0] intra_last_i,
  input  logic [lcu_sched_pkg::LCU_CNT_WIDTH-1:0] inter_last_i,
  input  lcu_sched_pkg::engine_strobe_t           eng_done_i,
  output lcu_sched_pkg::engine_strobe_t           eng_start_o,
  output logic                                    cfg_load_o,
  output logic                                    sys_done_o
);
  import lcu_sched_pkg::*;

  phase_e                   cur_state;
  phase_e                   nxt_state;
  engine_strobe_t           done_flag;
  engine_strobe_t           req_cur;
  engine_strobe_t           start_q;
  logic [LCU_CNT_WIDTH-1:0] step_cnt;
  logic                     frame_start;
  logic                     step_done;
  logic                     last_step;
  logic                     sys_done_q;

  // engines each phase waits on, also the engines it starts
  function automatic engine_strobe_t req_of(phase_e ph);
    engine_strobe_t req;
    case (ph)
      I_S1, I_S5, P_S1, P_S2, P_S4: req = '{fetch: 1'b1, pre_i: 1'b0, enc: 1'b0};
      I_S2:                         req = '{fetch: 1'b1, pre_i: 1'b1, enc: 1'b0};
      I_S3:                         req = '{fetch: 1'b1, pre_i: 1'b1, enc: 1'b1};
      I_S4, P_S3:                   req = '{fetch: 1'b1, pre_i: 1'b0, enc: 1'b1};
      default:                      req = '0;
    endcase
    return req;
  endfunction

  // --------------------
  // step completion
  // --------------------
  assign frame_start = (cur_state == IDLE) && sys_start_i;
  assign req_cur     = req_of(cur_state);
  assign step_done   = (cur_state != IDLE) && ((done_flag & req_cur) == req_cur);

  always_comb begin
    case (cur_state)
      I_S3:       last_step = (step_cnt == intra_last_i);
      P_S3:       last_step = (step_cnt == inter_last_i);
      I_S5, P_S4: last_step = (step_cnt == LCU_CNT_WIDTH'(FINAL_STEPS - 1));
      default:    last_step = 1'b1;  // single step phases
    endcase
  end

  always_comb begin
    nxt_state = cur_state;
    case (cur_state)
      IDLE: if (sys_start_i) nxt_state = (slice_i == SLICE_I) ? I_S1 : P_S1;
      I_S1: if (step_done) nxt_state = I_S2;
      I_S2: if (step_done) nxt_state = I_S3;
      I_S3: if (step_done && last_step) nxt_state = I_S4;
      I_S4: if (step_done) nxt_state = I_S5;
      I_S5: if (step_done && last_step) nxt_state = IDLE;
      P_S1: if (step_done) nxt_state = P_S2;
      P_S2: if (step_done) nxt_state = P_S3;
      P_S3: if (step_done && last_step) nxt_state = P_S4;
      P_S4: if (step_done && last_step) nxt_state = IDLE;
      default: nxt_state = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cur_state <= IDLE;
    end else begin
      cur_state <= nxt_state;
    end
  end

  // step counter, restarts with each phase
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step_cnt <= '0;
    end else if (cur_state != nxt_state) begin
      step_cnt <= '0;
    end else if (step_done) begin
      step_cnt <= step_cnt + LCU_CNT_WIDTH'(1);
    end
  end

  // done flags collect one pulse per engine
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_flag <= '0;
    end else if (step_done) begin
      done_flag <= '0;
    end else begin
      done_flag <= done_flag | eng_done_i;
    end
  end

  // --------------------
  // start pulses and done
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_q <= '0;
    end else if (step_done || frame_start) begin
      start_q <= req_of(nxt_state);  // idle gives no starts
    end else begin
      start_q <= '0;
    end
  end

  // follows the next state so done drops together with the first starts
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sys_done_q <= 1'b0;
    end else begin
      sys_done_q <= (nxt_state == IDLE);
    end
  end

  assign eng_start_o = start_q;
  assign cfg_load_o  = frame_start;
  assign sys_done_o  = sys_done_q;

endmodule

`default_nettype wire

// File: lcu_frame_cfg.sv
/*
  Frame configuration holder. Latches slice type and step thresholds on load_i,
  so cfg_i may change freely during the frame.
  Thresholds are valid one cycle after load. slice_o bypasses the register
  in the load cycle so the scheduler can pick the schedule at once.
*/
`timescale 1ns/1ps
`default_nettype none

module lcu_frame_cfg (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    load_i,
  input  lcu_sched_pkg::frame_cfg_t               cfg_i,
  output lcu_sched_pkg::slice_e                   slice_o,
  output logic [lcu_sched_pkg::LCU_CNT_WIDTH-1:0] intra_last_o,
  output logic [lcu_sched_pkg::LCU_CNT_WIDTH-1:0] inter_last_o
);
  import lcu_sched_pkg::*;

  logic [LCU_CNT_WIDTH-1:0] x_lcus;
  logic [LCU_CNT_WIDTH-1:0] y_lcus;
  logic [LCU_CNT_WIDTH-1:0] lcu_total;
  logic [LCU_CNT_WIDTH-1:0] intra_last_q;
  logic [LCU_CNT_WIDTH-1:0] inter_last_q;
  slice_e                   slice_q;

  // frame size product, evaluated only in the load cycle
  assign x_lcus    = LCU_CNT_WIDTH'(cfg_i.x_total) + LCU_CNT_WIDTH'(1);
  assign y_lcus    = LCU_CNT_WIDTH'(cfg_i.y_total) + LCU_CNT_WIDTH'(1);
  assign lcu_total = x_lcus * y_lcus;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slice_q      <= SLICE_I;
      intra_last_q <= '0;
      inter_last_q <= '0;
    end else if (load_i) begin
      slice_q      <= cfg_i.slice;
      intra_last_q <= lcu_total - LCU_CNT_WIDTH'(1);
      inter_last_q <= lcu_total + LCU_CNT_WIDTH'(INTER_EXTRA - 1);
    end
  end

  assign slice_o      = load_i ? cfg_i.slice : slice_q;  // schedule pick in idle
  assign intra_last_o = intra_last_q;
  assign inter_last_o = inter_last_q;

endmodule

`default_nettype wire

// File: mode_buf_pkg.sv
/*
  Intra mode buffer definitions.
  One bank holds the modes of one LCU. Addresses at or above MODE_DEPTH are
  outside the memory and must not be used.
*/
`default_nettype none

package mode_buf_pkg;

  localparam int MODE_DEPTH = 85;  // 64 + 16 + 4 + 1 partitions
  localparam int MODE_AW    = 7;
  localparam int MODE_DW    = 6;

  // write request from pre_i
  typedef struct packed {
    logic               we;
    logic [MODE_AW-1:0] addr;
    logic [MODE_DW-1:0] data;
  } mode_wr_t;

endpackage

`default_nettype wire

// File: lcu_sched_pkg.sv
/*
  Scheduler definitions: phase encoding, slice type, frame config and engine strobes.
  Frame sizes are LCU totals minus one. The product of the two totals must fit
  in LCU_CNT_WIDTH bits.
*/
`default_nettype none

package lcu_sched_pkg;

  localparam int PIC_X_WIDTH   = 8;
  localparam int PIC_Y_WIDTH   = 8;
  localparam int LCU_CNT_WIDTH = 16;
  localparam int FINAL_STEPS   = 3;  // drain steps at frame end
  localparam int INTER_EXTRA   = 3;  // P encode runs past the last lcu

  typedef enum logic [3:0] {
    IDLE,
    I_S1, I_S2, I_S3, I_S4, I_S5,
    P_S1, P_S2, P_S3, P_S4
  } phase_e;

  typedef enum logic {
    SLICE_I,
    SLICE_P
  } slice_e;

  typedef struct packed {
    logic [PIC_X_WIDTH-1:0] x_total;  // lcu columns - 1
    logic [PIC_Y_WIDTH-1:0] y_total;  // lcu rows - 1
    slice_e                 slice;
  } frame_cfg_t;

  // one bit per engine, for starts and dones alike
  typedef struct packed {
    logic fetch;
    logic pre_i;
    logic enc;
  } engine_strobe_t;

endpackage

`default_nettype wire
